// ==== icache.sv ====
module icache
    import icache_pkg::*;
#(
    parameter int set_bits = 5,
    parameter int tlb_entries = 8
) (
    input  logic                           clk,
    input  logic                           rst_n,

    // fetch stage
    input  logic                           req_valid,
    output logic                           req_ready,
    input  logic [addr_w-1:0]              req_address,
    output logic                           dp_valid,
    input  logic                           dp_ready,
    output logic [line_w-1:0]              dp_read_data,
    output logic                           dp_fault,

    // TLB load port
    input  logic                           tlb_wr_en,
    input  logic [$clog2(tlb_entries)-1:0] tlb_wr_idx,
    input  logic [addr_w-page_bits-1:0]    tlb_wr_vpn,
    input  logic [addr_w-page_bits-1:0]    tlb_wr_ppn,

    // interconnect
    output logic                           mem_req,
    output logic [addr_w-1:0]              mem_addr,
    input  logic                           mem_data_valid,
    input  logic [bus_w-1:0]               mem_data,
    output logic                           mem_done,

    // arbiter chain
    input  logic                           grant_in,
    output logic                           grant_out,
    input  logic                           bus_busy_in,
    output logic                           bus_busy_out
);

    localparam int tag_w = addr_w - set_bits - offset_bits;

    logic [addr_w-1:0]   phys_addr;
    logic                tlb_hit;
    logic [set_bits-1:0] req_index;
    logic [set_bits-1:0] line_index;
    logic [tag_w-1:0]    line_tag;
    logic [line_w-1:0]   stored_line;
    logic [line_w-1:0]   fill_line;
    logic                pa_valid;
    logic                line_hit;
    logic                last_word;
    logic                use_fill_line;
    logic                pa_load;
    logic                lookup_en;
    logic                word_capture;
    logic                fill_write;

    // index bits sit inside the page offset so the virtual index is the physical one
    assign req_index = req_address[offset_bits +: set_bits];

    itlb #(
        .tlb_entries (tlb_entries)
    ) i_itlb (
        .clk       (clk),
        .rst_n     (rst_n),
        .virt_addr (req_address),
        .phys_addr (phys_addr),
        .hit       (tlb_hit),
        .wr_en     (tlb_wr_en),
        .wr_idx    (tlb_wr_idx),
        .wr_vpn    (tlb_wr_vpn),
        .wr_ppn    (tlb_wr_ppn)
    );

    icache_tag_store #(
        .set_bits (set_bits)
    ) i_tag_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_index (req_index),
        .rd_en    (lookup_en),
        .wr_index (line_index),
        .wr_en    (fill_write),
        .wr_tag   (line_tag),
        .cmp_tag  (line_tag),
        .line_hit (line_hit)
    );

    icache_data_store #(
        .set_bits (set_bits)
    ) i_data_store (
        .clk      (clk),
        .rd_index (req_index),
        .rd_en    (lookup_en),
        .rd_line  (stored_line),
        .wr_index (line_index),
        .wr_en    (fill_write),
        .wr_line  (fill_line)
    );

    icache_line_fill #(
        .set_bits (set_bits)
    ) i_line_fill (
        .clk          (clk),
        .rst_n        (rst_n),
        .phys_addr    (phys_addr),
        .tlb_hit      (tlb_hit),
        .pa_load      (pa_load),
        .word_capture (word_capture),
        .mem_data     (mem_data),
        .mem_addr     (mem_addr),
        .line_index   (line_index),
        .line_tag     (line_tag),
        .pa_valid     (pa_valid),
        .last_word    (last_word),
        .line         (fill_line)
    );

    icache_controller i_controller (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .dp_valid       (dp_valid),
        .dp_ready       (dp_ready),
        .dp_fault       (dp_fault),
        .pa_valid       (pa_valid),
        .line_hit       (line_hit),
        .last_word      (last_word),
        .use_fill_line  (use_fill_line),
        .pa_load        (pa_load),
        .lookup_en      (lookup_en),
        .word_capture   (word_capture),
        .fill_write     (fill_write),
        .mem_req        (mem_req),
        .mem_data_valid (mem_data_valid),
        .mem_done       (mem_done),
        .grant_in       (grant_in),
        .grant_out      (grant_out),
        .bus_busy_in    (bus_busy_in),
        .bus_busy_out   (bus_busy_out)
    );

    // after a fill the array read is stale, so the buffer answers
    assign dp_read_data = dp_fault ? '0 : (use_fill_line ? fill_line : stored_line);

endmodule

// ==== icache_controller.sv ====
module icache_controller
    import icache_pkg::*;
(
    input  logic clk,
    input  logic rst_n,

    // fetch handshake
    input  logic req_valid,
    output logic req_ready,
    output logic dp_valid,
    input  logic dp_ready,
    output logic dp_fault,

    // datapath status
    input  logic pa_valid,
    input  logic line_hit,
    input  logic last_word,

    // datapath control
    output logic use_fill_line,
    output logic pa_load,
    output logic lookup_en,
    output logic word_capture,
    output logic fill_write,

    // bus
    output logic mem_req,
    input  logic mem_data_valid,
    output logic mem_done,

    // daisy chain arbitration
    input  logic grant_in,
    output logic grant_out,
    input  logic bus_busy_in,
    output logic bus_busy_out
);

    icache_state_e state;
    icache_state_e next_state;
    logic          accept;

    assign accept = req_valid && req_ready;

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (accept) begin
                    next_state = lookup;
                end
            end
            lookup: begin
                // a translation fault answers without touching the bus
                if (!pa_valid || line_hit) begin
                    next_state = respond;
                end else begin
                    next_state = arbitrate;
                end
            end
            arbitrate: begin
                if (grant_in && !bus_busy_in) begin
                    next_state = fill;
                end
            end
            fill: begin
                if (mem_data_valid && last_word) begin
                    next_state = write_line;
                end
            end
            write_line: begin
                next_state = respond;
            end
            respond: begin
                if (dp_ready) begin
                    next_state = idle;
                end
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    // ready is registered so it stays low until the first cycle out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            req_ready <= 1'b0;
            use_fill_line <= 1'b0;
        end else begin
            state <= next_state;
            req_ready <= (next_state == idle);
            if (accept) begin
                use_fill_line <= 1'b0;
            end else if (state == write_line) begin
                use_fill_line <= 1'b1;
            end
        end
    end

    assign pa_load = accept;
    assign lookup_en = accept;

    assign dp_valid = (state == respond);
    assign dp_fault = (state == respond) && !pa_valid;

    // one word per mem_data_valid edge while requesting
    assign mem_req = (state == fill);
    assign word_capture = (state == fill) && mem_data_valid;
    assign fill_write = (state == write_line);
    assign mem_done = (state == write_line);

    assign bus_busy_out = (state == fill) || (state == write_line);

    // hold the grant while waiting for or using the bus
    assign grant_out = grant_in && (state != arbitrate) && (state != fill);

endmodule

// ==== icache_data_store.sv ====
module icache_data_store
    import icache_pkg::*;
#(
    parameter int set_bits = 5
) (
    input  logic                clk,

    // synchronous read port
    input  logic [set_bits-1:0] rd_index,
    input  logic                rd_en,
    output logic [line_w-1:0]   rd_line,

    // fill write port
    input  logic [set_bits-1:0] wr_index,
    input  logic                wr_en,
    input  logic [line_w-1:0]   wr_line
);

    localparam int sets = 2 ** set_bits;

    logic [line_w-1:0] line_mem [sets];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            line_mem[wr_index] <= wr_line;
        end
        // output holds until the next accepted request
        if (rd_en) begin
            rd_line <= line_mem[rd_index];
        end
    end

endmodule

// ==== icache_line_fill.sv ====
module icache_line_fill
    import icache_pkg::*;
#(
    parameter int set_bits = 5
) (
    input  logic                                  clk,
    input  logic                                  rst_n,

    // translation result at acceptance
    input  logic [addr_w-1:0]                     phys_addr,
    input  logic                                  tlb_hit,
    input  logic                                  pa_load,

    // bus word capture
    input  logic                                  word_capture,
    input  logic [bus_w-1:0]                      mem_data,

    output logic [addr_w-1:0]                     mem_addr,
    output logic [set_bits-1:0]                   line_index,
    output logic [addr_w-set_bits-offset_bits-1:0] line_tag,
    output logic                                  pa_valid,
    output logic                                  last_word,
    output logic [line_w-1:0]                     line
);

    localparam int cnt_w = $clog2(words_per_line);

    logic [addr_w-1:0]                        addr_q;
    logic [cnt_w-1:0]                         word_cnt_q;
    logic [words_per_line-1:0][bus_w-1:0]     buf_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pa_valid <= 1'b0;
            word_cnt_q <= '0;
        end else if (pa_load) begin
            pa_valid <= tlb_hit;
            word_cnt_q <= '0;
        end else if (word_capture) begin
            word_cnt_q <= word_cnt_q + 1'b1;
        end
    end

    // only the offset field steps, so index and tag stay put through
    // the fill and the wrap after the last word
    always_ff @(posedge clk) begin
        if (pa_load) begin
            addr_q <= {phys_addr[addr_w-1:offset_bits], {offset_bits{1'b0}}};
        end else if (word_capture) begin
            addr_q[offset_bits-1:0] <= addr_q[offset_bits-1:0] + offset_bits'(4);
        end
    end

    // lowest address lands in the lowest word
    always_ff @(posedge clk) begin
        if (word_capture) begin
            buf_q[word_cnt_q] <= mem_data;
        end
    end

    assign last_word = (word_cnt_q == cnt_w'(words_per_line - 1));
    assign mem_addr = addr_q;
    assign line_index = addr_q[offset_bits +: set_bits];
    assign line_tag = addr_q[addr_w-1:offset_bits+set_bits];
    assign line = buf_q;

endmodule

// ==== icache_pkg.sv ====
package icache_pkg;

    // address and bus widths
    localparam int addr_w = 32;
    localparam int bus_w = 32;

    // 16 byte lines filled as four bus words
    localparam int line_w = 128;
    localparam int words_per_line = 4;
    localparam int offset_bits = 4;

    // 4 KB pages
    localparam int page_bits = 12;

    // controller states
    typedef enum logic [2:0] {
        // waiting for a fetch request
        idle,
        // tag compare on the registered read
        lookup,
        // waiting for grant with the bus free
        arbitrate,
        // four word reads on the bus
        fill,
        // line buffer goes into the arrays
        write_line,
        // response held until dp_ready
        respond
    } icache_state_e;

endpackage

// ==== icache_properties.sv ====
module icache_properties
    import icache_pkg::*;
(
    input logic              clk,
    input logic              rst_n,
    input logic              mem_req,
    input logic [addr_w-1:0] mem_addr,
    input logic              mem_data_valid,
    input logic              bus_busy_out,
    input logic              grant_out,
    input logic              dp_valid,
    input logic              dp_ready,
    input logic [line_w-1:0] dp_read_data,
    input logic              dp_fault
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // bus requests only while the cache owns the bus
    req_owns_bus: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |-> bus_busy_out)
        else begin
            fail_count++;
            $error("mem_req high without bus_busy_out");
        end

    // grant not passed on while busy
    grant_held: assert property (@(posedge clk) disable iff (!rst_n)
        !(grant_out && bus_busy_out))
        else begin
            fail_count++;
            $error("grant_out high while bus_busy_out high");
        end

    response_stable: assert property (@(posedge clk) disable iff (!rst_n)
        dp_valid && !dp_ready |=> dp_valid && $stable(dp_read_data) && $stable(dp_fault))
        else begin
            fail_count++;
            $error("response changed before dp_ready");
        end

    // address held until the word arrives
    addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_data_valid |=> mem_req && $stable(mem_addr))
        else begin
            fail_count++;
            $error("mem_addr changed while mem_req held");
        end

endmodule

bind icache icache_properties i_icache_properties (
    .clk            (clk),
    .rst_n          (rst_n),
    .mem_req        (mem_req),
    .mem_addr       (mem_addr),
    .mem_data_valid (mem_data_valid),
    .bus_busy_out   (bus_busy_out),
    .grant_out      (grant_out),
    .dp_valid       (dp_valid),
    .dp_ready       (dp_ready),
    .dp_read_data   (dp_read_data),
    .dp_fault       (dp_fault)
);

// ==== icache_tag_store.sv ====
module icache_tag_store
    import icache_pkg::*;
#(
    parameter int set_bits = 5
) (
    input  logic                                  clk,
    input  logic                                  rst_n,

    // read at request acceptance
    input  logic [set_bits-1:0]                   rd_index,
    input  logic                                  rd_en,

    // fill write
    input  logic [set_bits-1:0]                   wr_index,
    input  logic                                  wr_en,
    input  logic [addr_w-set_bits-offset_bits-1:0] wr_tag,

    // compare against the registered physical tag
    input  logic [addr_w-set_bits-offset_bits-1:0] cmp_tag,
    output logic                                  line_hit
);

    localparam int tag_w = addr_w - set_bits - offset_bits;
    localparam int sets = 2 ** set_bits;

    logic [tag_w-1:0] tag_mem [sets];
    logic [sets-1:0]  valid_q;
    logic [tag_w-1:0] rd_tag_q;
    logic             rd_valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            if (wr_en) begin
                valid_q[wr_index] <= 1'b1;
            end
            if (rd_en) begin
                rd_valid_q <= valid_q[rd_index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index] <= wr_tag;
        end
        if (rd_en) begin
            rd_tag_q <= tag_mem[rd_index];
        end
    end

    assign line_hit = rd_valid_q && (rd_tag_q == cmp_tag);

endmodule

// ==== itlb.sv ====
module itlb
    import icache_pkg::*;
#(
    parameter int tlb_entries = 8
) (
    input  logic                              clk,
    input  logic                              rst_n,

    // lookup side
    input  logic [addr_w-1:0]                 virt_addr,
    output logic [addr_w-1:0]                 phys_addr,
    output logic                              hit,

    // load port
    input  logic                              wr_en,
    input  logic [$clog2(tlb_entries)-1:0]    wr_idx,
    input  logic [addr_w-page_bits-1:0]       wr_vpn,
    input  logic [addr_w-page_bits-1:0]       wr_ppn
);

    localparam int vpn_w = addr_w - page_bits;

    logic [tlb_entries-1:0] valid_q;
    logic [vpn_w-1:0]       vpn_q [tlb_entries];
    logic [vpn_w-1:0]       ppn_q [tlb_entries];
    logic [vpn_w-1:0]       match_ppn;

    // an entry turns valid when it is loaded
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            vpn_q[wr_idx] <= wr_vpn;
            ppn_q[wr_idx] <= wr_ppn;
        end
    end

    // search runs high to low so the lowest matching index ends up selected
    always_comb begin
        hit = 1'b0;
        match_ppn = '0;
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if (valid_q[i] && (vpn_q[i] == virt_addr[addr_w-1:page_bits])) begin
                hit = 1'b1;
                match_ppn = ppn_q[i];
            end
        end
    end

    // page offset passes through untranslated
    assign phys_addr = {match_ppn, virt_addr[page_bits-1:0]};

endmodule

// ==== list.f ====
icache_pkg.sv
itlb.sv
icache_tag_store.sv
icache_data_store.sv
icache_line_fill.sv
icache_controller.sv
icache.sv
icache_properties.sv
tb_icache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the icache testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_icache -f list.f -o vsim_icache
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

# keep running past assertion errors so the testbench can report them
./obj_dir/vsim_icache +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$log"; then
    exit 1
fi
exit 0

// ==== tb_icache.sv ====
module tb_icache
    import icache_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int set_bits = 5;
    localparam int tlb_entries = 8;
    localparam int sets = 2 ** set_bits;
    localparam int vpn_w = addr_w - page_bits;
    localparam int tag_w = addr_w - set_bits - offset_bits;
    localparam int num_directed = 10;
    localparam int num_random = 40;
    // reset and TLB loading on top of the per request budget
    localparam int cycle_limit = (num_directed + num_random) * 200 + 50;

    logic                           clk;
    logic                           rst_n;
    logic                           req_valid;
    logic                           req_ready;
    logic [addr_w-1:0]              req_address;
    logic                           dp_valid;
    logic                           dp_ready = 1'b0;
    logic [line_w-1:0]              dp_read_data;
    logic                           dp_fault;
    logic                           tlb_wr_en;
    logic [$clog2(tlb_entries)-1:0] tlb_wr_idx;
    logic [vpn_w-1:0]               tlb_wr_vpn;
    logic [vpn_w-1:0]               tlb_wr_ppn;
    logic                           mem_req;
    logic [addr_w-1:0]              mem_addr;
    logic                           mem_data_valid = 1'b0;
    logic [bus_w-1:0]               mem_data = '0;
    logic                           mem_done;
    logic                           grant_in = 1'b0;
    logic                           grant_out;
    logic                           bus_busy_in = 1'b0;
    logic                           bus_busy_out;

    // testbench copy of the mappings and of the cache contents
    logic [vpn_w-1:0]  map_vpn [4];
    logic [vpn_w-1:0]  map_ppn [4];
    logic [vpn_w-1:0]  test_vpn [5];
    logic              shadow_valid [sets];
    logic [tag_w-1:0]  shadow_tag [sets];

    // one entry per issued request until its response
    logic [line_w-1:0] exp_line_q [$];
    logic              exp_fault_q [$];
    logic [addr_w-1:0] exp_base_q [$];
    int                exp_fills_q [$];

    int   error_count = 0;
    int   check_count = 0;
    int   issued = 0;
    int   resp_count = 0;
    int   exp_fill_total = 0;
    int   fill_count = 0;
    int   done_count = 0;
    int   word_idx = 0;
    int   mem_wait = 0;
    int   arb_mode = 0;
    int   phase_left = 0;
    logic mem_req_q = 1'b0;
    logic mem_done_q = 1'b0;
    logic take_q = 1'b0;

    icache #(
        .set_bits    (set_bits),
        .tlb_entries (tlb_entries)
    ) i_icache (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_address    (req_address),
        .dp_valid       (dp_valid),
        .dp_ready       (dp_ready),
        .dp_read_data   (dp_read_data),
        .dp_fault       (dp_fault),
        .tlb_wr_en      (tlb_wr_en),
        .tlb_wr_idx     (tlb_wr_idx),
        .tlb_wr_vpn     (tlb_wr_vpn),
        .tlb_wr_ppn     (tlb_wr_ppn),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_data_valid (mem_data_valid),
        .mem_data       (mem_data),
        .mem_done       (mem_done),
        .grant_in       (grant_in),
        .grant_out      (grant_out),
        .bus_busy_in    (bus_busy_in),
        .bus_busy_out   (bus_busy_out)
    );

    always #2 clk = ~clk;

    task automatic check_value(input logic [line_w-1:0] actual,
                               input logic [line_w-1:0] expected, input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // memory word is the address rotated left by 7 and xored with a constant
    function automatic logic [bus_w-1:0] mem_word(input logic [addr_w-1:0] addr);
        return {addr[addr_w-8:0], addr[addr_w-1:addr_w-7]} ^ 32'hc3a5_1e69;
    endfunction

    function automatic logic [line_w-1:0] expected_line(input logic [addr_w-1:0] base);
        logic [line_w-1:0] line;
        for (int w = 0; w < words_per_line; w++) begin
            line[w*bus_w +: bus_w] = mem_word(base + addr_w'(4 * w));
        end
        return line;
    endfunction

    // translate, predict hit or miss and update the shadow tags
    function automatic void predict(input logic [addr_w-1:0] va, output logic fault,
                                    output logic miss, output logic [line_w-1:0] line,
                                    output logic [addr_w-1:0] base);
        logic [addr_w-1:0] pa;
        logic              mapped;
        int                idx;
        mapped = 1'b0;
        pa = '0;
        // lowest matching entry wins
        for (int i = 3; i >= 0; i--) begin
            if (map_vpn[i] == va[addr_w-1:page_bits]) begin
                mapped = 1'b1;
                pa = {map_ppn[i], va[page_bits-1:0]};
            end
        end
        pa[offset_bits-1:0] = '0;
        fault = !mapped;
        miss = 1'b0;
        line = '0;
        if (mapped) begin
            idx = int'(pa[offset_bits +: set_bits]);
            miss = !(shadow_valid[idx] && shadow_tag[idx] == pa[addr_w-1:offset_bits+set_bits]);
            shadow_valid[idx] = 1'b1;
            shadow_tag[idx] = pa[addr_w-1:offset_bits+set_bits];
            line = expected_line(pa);
        end
        base = pa;
    endfunction

    task automatic load_tlb(input int idx, input logic [vpn_w-1:0] vpn,
                            input logic [vpn_w-1:0] ppn);
        @(negedge clk);
        tlb_wr_en = 1'b1;
        tlb_wr_idx = idx[$clog2(tlb_entries)-1:0];
        tlb_wr_vpn = vpn;
        tlb_wr_ppn = ppn;
        map_vpn[idx] = vpn;
        map_ppn[idx] = ppn;
        @(negedge clk);
        tlb_wr_en = 1'b0;
    endtask

    task automatic fetch(input logic [addr_w-1:0] va);
        logic              fault;
        logic              miss;
        logic [line_w-1:0] line;
        logic [addr_w-1:0] base;
        predict(va, fault, miss, line, base);
        if (miss) begin
            exp_fill_total++;
        end
        exp_line_q.push_back(line);
        exp_fault_q.push_back(fault);
        exp_base_q.push_back(base);
        exp_fills_q.push_back(exp_fill_total);
        issued++;
        repeat ($urandom_range(0, 2)) @(negedge clk);
        @(negedge clk);
        req_valid = 1'b1;
        req_address = va;
        @(posedge clk);
        while (!req_ready) @(posedge clk);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    // memory answers a held mem_req after 0 to 3 cycles
    always @(negedge clk) begin
        if (!mem_req) begin
            mem_data_valid = 1'b0;
            mem_wait = $urandom_range(0, 3);
        end else if (mem_wait == 0) begin
            mem_data_valid = 1'b1;
            mem_data = mem_word(mem_addr);
            mem_wait = $urandom_range(0, 3);
        end else begin
            mem_data_valid = 1'b0;
            mem_wait--;
        end
    end

    // arbiter phases with the grant given, withheld or the bus busy elsewhere
    always @(negedge clk) begin
        if (!rst_n || bus_busy_out) begin
            // no grant while the cache owns the bus
            grant_in = 1'b0;
            bus_busy_in = 1'b0;
        end else begin
            if (phase_left == 0) begin
                arb_mode = $urandom_range(0, 3);
                phase_left = $urandom_range(1, 6);
            end else begin
                phase_left--;
            end
            grant_in = (arb_mode != 1);
            bus_busy_in = (arb_mode == 2);
        end
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            dp_ready = 1'b0;
        end else begin
            dp_ready = ($urandom_range(0, 3) != 0);
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (req_ready) begin
                check_value(line_w'(grant_out), line_w'(grant_in), "grant_out while idle");
            end
            check_value(line_w'(dp_valid && req_ready), '0, "ready while response pending");
            // the first mem_req follows the edge that took the bus
            if (mem_req && !mem_req_q) begin
                fill_count++;
                word_idx = 0;
                check_value(line_w'(take_q), line_w'(1), "bus taken before mem_req");
            end
            if (mem_req && mem_data_valid) begin
                if (exp_base_q.size() == 0) begin
                    error_count++;
                    $display("bus read at %0t ns with no request outstanding", $time);
                end else begin
                    check_value(line_w'(mem_addr), line_w'(exp_base_q[0] + addr_w'(4 * word_idx)),
                                "fill word address");
                end
                word_idx++;
            end
            if (mem_done) begin
                done_count++;
                check_value(line_w'(mem_done_q), '0, "mem_done longer than one cycle");
            end
            if (dp_valid && dp_ready) begin
                if (exp_line_q.size() == 0) begin
                    error_count++;
                    $display("response at %0t ns with no request outstanding", $time);
                end else begin
                    check_value(dp_read_data, exp_line_q[0], "response line");
                    check_value(line_w'(dp_fault), line_w'(exp_fault_q[0]), "response fault");
                    check_value(line_w'(fill_count), line_w'(exp_fills_q[0]), "fills so far");
                    check_value(line_w'(done_count), line_w'(exp_fills_q[0]), "mem_done so far");
                    void'(exp_line_q.pop_front());
                    void'(exp_fault_q.pop_front());
                    void'(exp_base_q.pop_front());
                    void'(exp_fills_q.pop_front());
                end
                resp_count++;
            end
        end
        mem_req_q = mem_req;
        mem_done_q = mem_done;
        take_q = grant_in && !bus_busy_in;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run still busy after %0d cycles, %0d of %0d responses seen",
                 cycle_limit, resp_count, issued);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int page;
        int ln;
        int off;
        void'($urandom(32'h090356bd));
        clk = 1'b0;
        rst_n = 1'b0;
        req_valid = 1'b0;
        req_address = '0;
        tlb_wr_en = 1'b0;
        tlb_wr_idx = '0;
        tlb_wr_vpn = '0;
        tlb_wr_ppn = '0;
        for (int s = 0; s < sets; s++) begin
            shadow_valid[s] = 1'b0;
            shadow_tag[s] = '0;
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        check_value(line_w'({dp_valid, mem_req, mem_done, bus_busy_out, req_ready}), '0,
                    "outputs out of reset");

        // last page aliases the first physical page
        load_tlb(0, 20'h00010, 20'h00200);
        load_tlb(1, 20'h00011, 20'h00201);
        load_tlb(2, 20'h00020, 20'h00300);
        load_tlb(3, 20'h00031, 20'h00200);
        test_vpn[0] = 20'h00010;
        test_vpn[1] = 20'h00011;
        test_vpn[2] = 20'h00020;
        test_vpn[3] = 20'h00031;
        test_vpn[4] = 20'h00050;

        // miss then hits on the same line
        fetch(32'h0001_0040);
        fetch(32'h0001_0040);
        fetch(32'h0001_004c);
        // same index with different tags
        fetch(32'h0001_1044);
        fetch(32'h0001_0048);
        fetch(32'h0001_1040);
        fetch(32'h0003_1040);
        fetch(32'h0001_0040);
        // unmapped page
        fetch(32'h0005_0010);
        fetch(32'h0005_0ff0);

        for (int n = 0; n < num_random; n++) begin
            page = $urandom_range(0, 4);
            ln = $urandom_range(0, 7);
            off = $urandom_range(0, 15);
            fetch({test_vpn[page], 12'h000} | addr_w'(ln * 16 + off));
        end

        while (resp_count < issued) @(posedge clk);
        repeat (4) @(posedge clk);
        check_value(line_w'(fill_count), line_w'(exp_fill_total), "total fills");
        check_value(line_w'(done_count), line_w'(fill_count), "mem_done pulses per fill");
        error_count = error_count + i_icache.i_icache_properties.fail_count;

        $display("%0d requests, %0d checks, %0d errors, %0d assertion failures",
                 issued, check_count, error_count, i_icache.i_icache_properties.fail_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
